//--- src/exec_pkg.sv
package exec_pkg;

    // ========================================================================
    // Execute stage control encodings
    // ========================================================================

    // ALU operation select, lower values win
    typedef enum logic [3:0] {
        ALU_NONE = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_MUL  = 4'd2,
        ALU_SLL  = 4'd3,
        ALU_SRL  = 4'd4,
        ALU_SRA  = 4'd5,
        ALU_AND  = 4'd6,
        ALU_OR   = 4'd7,
        ALU_XOR  = 4'd8,
        ALU_PASS = 4'd9
    } alu_op_t;

    // Condition tested on the ALU result of a branch
    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_EQ0  = 2'd1,
        BR_GT0  = 2'd2,
        BR_LT0  = 2'd3
    } branch_cond_t;

    // ========================================================================
    // Fixed-width fields
    // ========================================================================

    // Cycle index within a multi-cycle instruction
    typedef logic [2:0] cycle_t;

    // Destination register index
    typedef logic [3:0] reg_idx_t;

endpackage

//--- src/exec_input_reg.sv
`timescale 1ns/1ps

module exec_input_reg import exec_pkg::*; #(
    parameter int WORD_WIDTH = 16,
    parameter int PC_WIDTH   = 12
) (
    input  logic                  clock,
    input  logic                  reset,
    input  alu_op_t               alu_op,
    input  logic                  neg_src2,
    input  branch_cond_t          branch_cond,
    input  logic                  jump,
    input  logic                  load_dmem,
    input  logic                  store_dmem,
    input  logic                  write_res,
    input  logic                  incr_pc_is_res,
    input  cycle_t                cycle_in_instr,
    input  logic                  flush,
    input  logic [PC_WIDTH-1:0]   pc,
    input  reg_idx_t              res_reg_idx,
    input  logic [WORD_WIDTH-1:0] src1,
    input  logic [WORD_WIDTH-1:0] src2,
    input  logic [WORD_WIDTH-1:0] src3,
    output alu_op_t               q_alu_op,
    output logic                  q_neg_src2,
    output branch_cond_t          q_branch_cond,
    output logic                  q_jump,
    output logic                  q_load,
    output logic                  q_store,
    output logic                  q_write_res,
    output logic                  q_incr_pc,
    output cycle_t                q_cycle,
    output logic [PC_WIDTH-1:0]   q_pc,
    output reg_idx_t              q_reg_idx,
    output logic [WORD_WIDTH-1:0] q_src1,
    output logic [WORD_WIDTH-1:0] q_src2,
    output logic [WORD_WIDTH-1:0] q_src3
);

    alu_op_t               alu_op_r;
    branch_cond_t          branch_cond_r;
    cycle_t                cycle_r;
    reg_idx_t              reg_idx_r;
    logic [PC_WIDTH-1:0]   pc_r;
    logic                  neg_src2_r;
    logic                  jump_r;
    logic                  load_r;
    logic                  store_r;
    logic                  write_res_r;
    logic                  incr_pc_r;
    logic                  flush_r;

    // ========================================================================
    // Stage input register
    // ========================================================================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            alu_op_r      <= ALU_NONE;
            branch_cond_r <= BR_NONE;
            cycle_r       <= '0;
            reg_idx_r     <= '0;
            pc_r          <= '0;
            neg_src2_r    <= 1'b0;
            jump_r        <= 1'b0;
            load_r        <= 1'b0;
            store_r       <= 1'b0;
            write_res_r   <= 1'b0;
            incr_pc_r     <= 1'b0;
            flush_r       <= 1'b0;
            q_src1        <= '0;
            q_src2        <= '0;
            q_src3        <= '0;
        end else begin
            alu_op_r      <= alu_op;
            branch_cond_r <= branch_cond;
            cycle_r       <= cycle_in_instr;
            reg_idx_r     <= res_reg_idx;
            pc_r          <= pc;
            neg_src2_r    <= neg_src2;
            jump_r        <= jump;
            load_r        <= load_dmem;
            store_r       <= store_dmem;
            write_res_r   <= write_res;
            incr_pc_r     <= incr_pc_is_res;
            flush_r       <= flush;
            q_src1        <= src1;
            q_src2        <= src2;
            q_src3        <= src3;
        end
    end

    // Flushed slot looks like an idle instruction to the rest of the stage
    always_comb begin
        if (flush_r) begin
            q_alu_op      = ALU_NONE;
            q_branch_cond = BR_NONE;
            q_neg_src2    = 1'b0;
            q_jump        = 1'b0;
            q_load        = 1'b0;
            q_store       = 1'b0;
            q_write_res   = 1'b0;
            q_incr_pc     = 1'b0;
            q_cycle       = '0;
            q_pc          = '0;
            q_reg_idx     = '0;
        end else begin
            q_alu_op      = alu_op_r;
            q_branch_cond = branch_cond_r;
            q_neg_src2    = neg_src2_r;
            q_jump        = jump_r;
            q_load        = load_r;
            q_store       = store_r;
            q_write_res   = write_res_r;
            q_incr_pc     = incr_pc_r;
            q_cycle       = cycle_r;
            q_pc          = pc_r;
            q_reg_idx     = reg_idx_r;
        end
    end

    // Decode must never issue a load and a store in the same slot
    a_no_load_and_store: assert property (
        @(posedge clock) disable iff (reset) !(q_load && q_store)
    ) else $error("load and store issued together");

endmodule

//--- src/int_alu.sv
`timescale 1ns/1ps

module int_alu import exec_pkg::*; #(
    parameter int WORD_WIDTH = 16
) (
    input  alu_op_t               alu_op,
    input  logic                  neg_src2,
    input  logic [WORD_WIDTH-1:0] src1,
    input  logic [WORD_WIDTH-1:0] src2,
    output logic [WORD_WIDTH-1:0] alu_res
);

    // Second operand after optional two's complement
    logic [WORD_WIDTH-1:0] src2_mod;

    assign src2_mod = neg_src2 ? (~src2 + 1'b1) : src2;

    // ========================================================================
    // Operation select
    // ========================================================================
    always_comb begin
        case (alu_op)
            // Subtract is add with neg_src2 set
            ALU_ADD: begin
                alu_res = src1 + src2_mod;
            end
            // Low half of the product only
            ALU_MUL: begin
                alu_res = src1 * src2_mod;
            end
            // Full src2 is the shift amount, so large amounts flush the word
            ALU_SLL: begin
                alu_res = src1 << src2_mod;
            end
            ALU_SRL: begin
                alu_res = src1 >> src2_mod;
            end
            ALU_SRA: begin
                alu_res = $signed(src1) >>> src2_mod;
            end
            ALU_AND: begin
                alu_res = src1 & src2_mod;
            end
            ALU_OR: begin
                alu_res = src1 | src2_mod;
            end
            ALU_XOR: begin
                alu_res = src1 ^ src2_mod;
            end
            // Immediate or register move
            ALU_PASS: begin
                alu_res = src2_mod;
            end
            default: begin
                alu_res = '0;
            end
        endcase
    end

endmodule

//--- src/branch_unit.sv
`timescale 1ns/1ps

module branch_unit import exec_pkg::*; #(
    parameter int WORD_WIDTH = 16,
    parameter int PC_WIDTH   = 12
) (
    input  logic                  clock,
    input  logic                  reset,
    input  branch_cond_t          branch_cond,
    input  logic                  jump,
    input  cycle_t                cycle_in_instr,
    input  logic [WORD_WIDTH-1:0] alu_res,
    output logic                  set_pc,
    output logic [PC_WIDTH-1:0]   branch_pc,
    output logic                  flush_if,
    output logic                  flush_dc_ex
);

    // ALU result of the previous cycle
    logic [WORD_WIDTH-1:0] alu_res_q;
    logic                  cond_now;
    logic                  cond_prev;

    // Branch condition on one ALU value
    function automatic logic cond_holds(
        input branch_cond_t          cond,
        input logic [WORD_WIDTH-1:0] value
    );
        logic result;
        case (cond)
            BR_EQ0:  result = (value == '0);
            BR_GT0:  result = !value[WORD_WIDTH-1] && (value != '0);
            BR_LT0:  result = value[WORD_WIDTH-1];
            default: result = 1'b0;
        endcase
        return result;
    endfunction

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            alu_res_q <= '0;
        end else begin
            alu_res_q <= alu_res;
        end
    end

    assign cond_now  = cond_holds(branch_cond, alu_res);
    assign cond_prev = cond_holds(branch_cond, alu_res_q);

    // ========================================================================
    // Jump and branch decision
    // ========================================================================
    always_comb begin
        set_pc      = 1'b0;
        flush_if    = 1'b0;
        flush_dc_ex = 1'b0;
        branch_pc   = '0;
        if (jump) begin
            set_pc      = 1'b1;
            flush_if    = 1'b1;
            flush_dc_ex = 1'b1;
            branch_pc   = alu_res[PC_WIDTH-1:0];
        end else if (cycle_in_instr == cycle_t'(0) && cond_now) begin
            // First cycle only kills the fetch while the target is computed
            flush_if = 1'b1;
        end else if (cycle_in_instr == cycle_t'(1) && cond_prev) begin
            // Second cycle takes the condition from the stored result
            set_pc      = 1'b1;
            flush_if    = 1'b1;
            flush_dc_ex = 1'b1;
            branch_pc   = alu_res[PC_WIDTH-1:0];
        end
    end

    // Stored result is only meaningful right after the first cycle of the same branch
    a_branch_cycle_order: assert property (
        @(posedge clock) disable iff (reset)
        (branch_cond != BR_NONE && cycle_in_instr == cycle_t'(1)) |->
            ($past(branch_cond) == branch_cond && $past(cycle_in_instr) == cycle_t'(0))
    ) else $error("branch cycle 1 without a matching cycle 0");

endmodule

//--- src/exec_outputs.sv
`timescale 1ns/1ps

module exec_outputs import exec_pkg::*; #(
    parameter int WORD_WIDTH      = 16,
    parameter int PC_WIDTH        = 12,
    parameter int DMEM_ADDR_WIDTH = 12,
    parameter int PC_INCREMENT    = 2
) (
    input  logic                       q_load,
    input  logic                       q_store,
    input  logic                       q_write_res,
    input  logic                       q_incr_pc,
    input  logic [PC_WIDTH-1:0]        q_pc,
    input  reg_idx_t                   q_reg_idx,
    input  logic [WORD_WIDTH-1:0]      q_src3,
    input  logic [WORD_WIDTH-1:0]      alu_res,
    output logic                       out_load_dmem,
    output logic                       out_store_dmem,
    output logic                       out_write_res,
    output logic [PC_WIDTH-1:0]        out_pc,
    output reg_idx_t                   out_res_reg_idx,
    output logic [DMEM_ADDR_WIDTH-1:0] dmem_rd_addr,
    output logic [DMEM_ADDR_WIDTH-1:0] dmem_wr_addr,
    output logic [WORD_WIDTH-1:0]      dmem_wr_word,
    output logic [WORD_WIDTH-1:0]      res
);

    // Return address, wraps within the PC width
    logic [PC_WIDTH-1:0] ret_pc;

    assign ret_pc = q_pc + PC_WIDTH'(PC_INCREMENT);

    // ========================================================================
    // Data memory addressing
    // ========================================================================
    assign dmem_rd_addr = q_load  ? alu_res[DMEM_ADDR_WIDTH-1:0] : '0;
    assign dmem_wr_addr = q_store ? alu_res[DMEM_ADDR_WIDTH-1:0] : '0;
    assign dmem_wr_word = q_store ? q_src3 : '0;

    // Result is the ALU value or the return address of a call
    assign res = q_incr_pc ? WORD_WIDTH'(ret_pc) : alu_res;

    // Controls for the memory stage
    assign out_load_dmem   = q_load;
    assign out_store_dmem  = q_store;
    assign out_write_res   = q_write_res;
    assign out_pc          = q_pc;
    assign out_res_reg_idx = q_reg_idx;

endmodule

//--- src/exec_stage.sv
`timescale 1ns/1ps

module exec_stage import exec_pkg::*; #(
    parameter int WORD_WIDTH      = 16,
    parameter int PC_WIDTH        = 12,
    parameter int DMEM_ADDR_WIDTH = 12,
    parameter int PC_INCREMENT    = 2
) (
    input  logic                       clock,
    input  logic                       reset,
    input  alu_op_t                    alu_op,
    input  logic                       neg_src2,
    input  branch_cond_t               branch_cond,
    input  logic                       jump,
    input  logic                       load_dmem,
    input  logic                       store_dmem,
    input  logic                       write_res,
    input  logic                       incr_pc_is_res,
    input  cycle_t                     cycle_in_instr,
    input  logic                       flush,
    input  logic [PC_WIDTH-1:0]        pc,
    input  reg_idx_t                   res_reg_idx,
    input  logic [WORD_WIDTH-1:0]      src1,
    input  logic [WORD_WIDTH-1:0]      src2,
    input  logic [WORD_WIDTH-1:0]      src3,
    output logic                       out_load_dmem,
    output logic                       out_store_dmem,
    output logic                       out_write_res,
    output logic [PC_WIDTH-1:0]        out_pc,
    output reg_idx_t                   out_res_reg_idx,
    output logic [WORD_WIDTH-1:0]      res,
    output logic [DMEM_ADDR_WIDTH-1:0] dmem_rd_addr,
    output logic [DMEM_ADDR_WIDTH-1:0] dmem_wr_addr,
    output logic [WORD_WIDTH-1:0]      dmem_wr_word,
    output logic                       set_pc,
    output logic [PC_WIDTH-1:0]        branch_pc,
    output logic                       flush_if,
    output logic                       flush_dc_ex
);

    // Registered and flush-masked stage inputs
    alu_op_t               q_alu_op;
    branch_cond_t          q_branch_cond;
    cycle_t                q_cycle;
    reg_idx_t              q_reg_idx;
    logic [PC_WIDTH-1:0]   q_pc;
    logic                  q_neg_src2;
    logic                  q_jump;
    logic                  q_load;
    logic                  q_store;
    logic                  q_write_res;
    logic                  q_incr_pc;
    logic [WORD_WIDTH-1:0] q_src1;
    logic [WORD_WIDTH-1:0] q_src2;
    logic [WORD_WIDTH-1:0] q_src3;
    logic [WORD_WIDTH-1:0] alu_res;

    // ========================================================================
    // Input register
    // ========================================================================
    exec_input_reg #(
        .WORD_WIDTH (WORD_WIDTH),
        .PC_WIDTH   (PC_WIDTH)
    ) i_exec_input_reg (
        .clock          (clock),
        .reset          (reset),
        .alu_op         (alu_op),
        .neg_src2       (neg_src2),
        .branch_cond    (branch_cond),
        .jump           (jump),
        .load_dmem      (load_dmem),
        .store_dmem     (store_dmem),
        .write_res      (write_res),
        .incr_pc_is_res (incr_pc_is_res),
        .cycle_in_instr (cycle_in_instr),
        .flush          (flush),
        .pc             (pc),
        .res_reg_idx    (res_reg_idx),
        .src1           (src1),
        .src2           (src2),
        .src3           (src3),
        .q_alu_op       (q_alu_op),
        .q_neg_src2     (q_neg_src2),
        .q_branch_cond  (q_branch_cond),
        .q_jump         (q_jump),
        .q_load         (q_load),
        .q_store        (q_store),
        .q_write_res    (q_write_res),
        .q_incr_pc      (q_incr_pc),
        .q_cycle        (q_cycle),
        .q_pc           (q_pc),
        .q_reg_idx      (q_reg_idx),
        .q_src1         (q_src1),
        .q_src2         (q_src2),
        .q_src3         (q_src3)
    );

    // ========================================================================
    // ALU, branch and output logic
    // ========================================================================
    int_alu #(
        .WORD_WIDTH (WORD_WIDTH)
    ) i_int_alu (
        .alu_op   (q_alu_op),
        .neg_src2 (q_neg_src2),
        .src1     (q_src1),
        .src2     (q_src2),
        .alu_res  (alu_res)
    );

    branch_unit #(
        .WORD_WIDTH (WORD_WIDTH),
        .PC_WIDTH   (PC_WIDTH)
    ) i_branch_unit (
        .clock          (clock),
        .reset          (reset),
        .branch_cond    (q_branch_cond),
        .jump           (q_jump),
        .cycle_in_instr (q_cycle),
        .alu_res        (alu_res),
        .set_pc         (set_pc),
        .branch_pc      (branch_pc),
        .flush_if       (flush_if),
        .flush_dc_ex    (flush_dc_ex)
    );

    exec_outputs #(
        .WORD_WIDTH      (WORD_WIDTH),
        .PC_WIDTH        (PC_WIDTH),
        .DMEM_ADDR_WIDTH (DMEM_ADDR_WIDTH),
        .PC_INCREMENT    (PC_INCREMENT)
    ) i_exec_outputs (
        .q_load          (q_load),
        .q_store         (q_store),
        .q_write_res     (q_write_res),
        .q_incr_pc       (q_incr_pc),
        .q_pc            (q_pc),
        .q_reg_idx       (q_reg_idx),
        .q_src3          (q_src3),
        .alu_res         (alu_res),
        .out_load_dmem   (out_load_dmem),
        .out_store_dmem  (out_store_dmem),
        .out_write_res   (out_write_res),
        .out_pc          (out_pc),
        .out_res_reg_idx (out_res_reg_idx),
        .dmem_rd_addr    (dmem_rd_addr),
        .dmem_wr_addr    (dmem_wr_addr),
        .dmem_wr_word    (dmem_wr_word),
        .res             (res)
    );

endmodule

//--- test/exec_stage_tb.sv
`timescale 1ns/1ps

module exec_stage_tb import exec_pkg::*;;

    localparam int    CLOCK_PERIOD    = 20;
    localparam int    RESET_CYCLES    = 8;
    localparam int    WATCHDOG_MARGIN = 20;
    localparam int    MAX_LINES       = 128;
    localparam int    NUM_INPUTS      = 15;
    localparam int    NUM_OUTPUTS     = 13;
    localparam int    NUM_FIELDS      = NUM_INPUTS + NUM_OUTPUTS;
    localparam string STIM_FILE       = "test/exec_stimulus.txt";

    logic         clock;
    logic         reset;
    alu_op_t      alu_op;
    logic         neg_src2;
    branch_cond_t branch_cond;
    logic         jump;
    logic         load_dmem;
    logic         store_dmem;
    logic         write_res;
    logic         incr_pc_is_res;
    cycle_t       cycle_in_instr;
    logic         flush;
    logic [11:0]  pc;
    reg_idx_t     res_reg_idx;
    logic [15:0]  src1;
    logic [15:0]  src2;
    logic [15:0]  src3;
    logic         out_load_dmem;
    logic         out_store_dmem;
    logic         out_write_res;
    logic [11:0]  out_pc;
    reg_idx_t     out_res_reg_idx;
    logic [15:0]  res;
    logic [11:0]  dmem_rd_addr;
    logic [11:0]  dmem_wr_addr;
    logic [15:0]  dmem_wr_word;
    logic         set_pc;
    logic [11:0]  branch_pc;
    logic         flush_if;
    logic         flush_dc_ex;

    // One row per stimulus line, inputs first, then expected outputs
    logic [15:0] stim [MAX_LINES][NUM_FIELDS];
    int          line_test [MAX_LINES];
    string       test_names[$];
    int          n_lines;
    int          cur_line;
    bit          stim_loaded;
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;

    exec_stage #(
        .WORD_WIDTH      (16),
        .PC_WIDTH        (12),
        .DMEM_ADDR_WIDTH (12),
        .PC_INCREMENT    (2)
    ) i_exec_stage (
        .clock           (clock),
        .reset           (reset),
        .alu_op          (alu_op),
        .neg_src2        (neg_src2),
        .branch_cond     (branch_cond),
        .jump            (jump),
        .load_dmem       (load_dmem),
        .store_dmem      (store_dmem),
        .write_res       (write_res),
        .incr_pc_is_res  (incr_pc_is_res),
        .cycle_in_instr  (cycle_in_instr),
        .flush           (flush),
        .pc              (pc),
        .res_reg_idx     (res_reg_idx),
        .src1            (src1),
        .src2            (src2),
        .src3            (src3),
        .out_load_dmem   (out_load_dmem),
        .out_store_dmem  (out_store_dmem),
        .out_write_res   (out_write_res),
        .out_pc          (out_pc),
        .out_res_reg_idx (out_res_reg_idx),
        .res             (res),
        .dmem_rd_addr    (dmem_rd_addr),
        .dmem_wr_addr    (dmem_wr_addr),
        .dmem_wr_word    (dmem_wr_word),
        .set_pc          (set_pc),
        .branch_pc       (branch_pc),
        .flush_if        (flush_if),
        .flush_dc_ex     (flush_dc_ex)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLOCK_PERIOD / 2);
            clock = ~clock;
        end
    end

    // ========================================================================
    // Stimulus file reader
    // ========================================================================

    // ASCII hex digit to its value, -1 for anything else
    function automatic int hex_value(input int c);
        int value;
        value = -1;
        if (c >= 48 && c <= 57) begin
            value = c - 48;
        end else if (c >= 97 && c <= 102) begin
            value = c - 87;
        end else if (c >= 65 && c <= 70) begin
            value = c - 55;
        end
        return value;
    endfunction

    task automatic load_stimulus(output bit ok);
        int          fd;
        int          code;
        int          count;
        int          digit;
        int          test_idx;
        bit          in_field;
        logic [15:0] acc;
        string       text;
        string       name;
        ok       = 1'b1;
        n_lines  = 0;
        test_idx = -1;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file %s", STIM_FILE);
            ok = 1'b0;
        end else begin
            while (ok && !$feof(fd)) begin
                code = $fgets(text, fd);
                if (code > 0 && text.len() > 1 && text.getc(0) != "#") begin
                    if ($sscanf(text, "test %s", name) == 1) begin
                        test_names.push_back(name);
                        test_idx = test_names.size() - 1;
                    end else begin
                        count    = 0;
                        in_field = 1'b0;
                        acc      = '0;
                        // One position past the end closes the last field
                        for (int i = 0; i <= text.len(); i++) begin
                            digit = (i < text.len()) ? hex_value(int'(text.getc(i))) : -1;
                            if (digit >= 0) begin
                                acc      = {acc[11:0], 4'(digit)};
                                in_field = 1'b1;
                            end else if (in_field) begin
                                if (count < NUM_FIELDS && n_lines < MAX_LINES) begin
                                    stim[n_lines][count] = acc;
                                end
                                count++;
                                acc      = '0;
                                in_field = 1'b0;
                            end
                        end
                        if (count != NUM_FIELDS) begin
                            $display("stimulus line %0d has %0d fields instead of %0d",
                                     n_lines, count, NUM_FIELDS);
                            ok = 1'b0;
                        end else if (test_idx < 0) begin
                            $display("stimulus data found before the first test name");
                            ok = 1'b0;
                        end else if (n_lines >= MAX_LINES) begin
                            $display("stimulus file has more than %0d lines", MAX_LINES);
                            ok = 1'b0;
                        end else begin
                            line_test[n_lines] = test_idx;
                            n_lines++;
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ========================================================================
    // Drive and compare
    // ========================================================================
    task automatic drive_idle();
        alu_op         = ALU_NONE;
        neg_src2       = 1'b0;
        branch_cond    = BR_NONE;
        jump           = 1'b0;
        load_dmem      = 1'b0;
        store_dmem     = 1'b0;
        write_res      = 1'b0;
        incr_pc_is_res = 1'b0;
        cycle_in_instr = '0;
        flush          = 1'b0;
        pc             = '0;
        res_reg_idx    = '0;
        src1           = '0;
        src2           = '0;
        src3           = '0;
    endtask

    task automatic drive_line(input int k);
        alu_op         = alu_op_t'(stim[k][0][3:0]);
        neg_src2       = stim[k][1][0];
        branch_cond    = branch_cond_t'(stim[k][2][1:0]);
        jump           = stim[k][3][0];
        load_dmem      = stim[k][4][0];
        store_dmem     = stim[k][5][0];
        write_res      = stim[k][6][0];
        incr_pc_is_res = stim[k][7][0];
        cycle_in_instr = stim[k][8][2:0];
        flush          = stim[k][9][0];
        pc             = stim[k][10][11:0];
        res_reg_idx    = stim[k][11][3:0];
        src1           = stim[k][12];
        src2           = stim[k][13];
        src3           = stim[k][14];
    endtask

    // Line index -1 stands for the all-zero reset state
    function automatic logic [15:0] expected_out(input int k, input int j);
        return (k < 0) ? 16'h0000 : stim[k][NUM_INPUTS + j];
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        if (got !== expected) begin
            $display("mismatch %s: got %h expected %h at stimulus line %0d",
                     name, got, expected, cur_line);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic check_outputs(input int k);
        check_value("out_load_dmem", 16'(out_load_dmem), expected_out(k, 0));
        check_value("out_store_dmem", 16'(out_store_dmem), expected_out(k, 1));
        check_value("out_write_res", 16'(out_write_res), expected_out(k, 2));
        check_value("out_pc", 16'(out_pc), expected_out(k, 3));
        check_value("out_res_reg_idx", 16'(out_res_reg_idx), expected_out(k, 4));
        check_value("res", res, expected_out(k, 5));
        check_value("dmem_rd_addr", 16'(dmem_rd_addr), expected_out(k, 6));
        check_value("dmem_wr_addr", 16'(dmem_wr_addr), expected_out(k, 7));
        check_value("dmem_wr_word", dmem_wr_word, expected_out(k, 8));
        check_value("set_pc", 16'(set_pc), expected_out(k, 9));
        check_value("branch_pc", 16'(branch_pc), expected_out(k, 10));
        check_value("flush_if", 16'(flush_if), expected_out(k, 11));
        check_value("flush_dc_ex", 16'(flush_dc_ex), expected_out(k, 12));
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", name, test_errors);
        end
        test_errors = 0;
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        bit loaded_ok;
        reset        = 1'b1;
        cur_line     = -1;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        drive_idle();
        load_stimulus(loaded_ok);
        stim_loaded = 1'b1;
        if (!loaded_ok) begin
            $display("Some tests failed");
            $finish;
        end else begin
            repeat (RESET_CYCLES) begin
                @(negedge clock);
                check_outputs(-1);
            end
            reset = 1'b0;
            report_test("reset_hold");
            // Outputs of line k-1 are checked on the edge that drives line k
            for (int k = 0; k <= n_lines; k++) begin
                @(negedge clock);
                if (k > 0) begin
                    cur_line = k - 1;
                    check_outputs(k - 1);
                    if (k == n_lines || line_test[k] != line_test[k - 1]) begin
                        report_test(test_names[line_test[k - 1]]);
                    end
                end
                if (k < n_lines) begin
                    drive_line(k);
                end else begin
                    drive_idle();
                end
            end
            $display("tests run %0d, tests failed %0d, mismatches %0d",
                     tests_run, tests_failed, total_errors);
            if (tests_failed == 0) begin
                $display("All tests passed");
            end else begin
                $display("Some tests failed");
            end
            $finish;
        end
    end

    // Watchdog sized from the number of stimulus lines
    initial begin
        wait (stim_loaded);
        #((RESET_CYCLES + n_lines + WATCHDOG_MARGIN) * CLOCK_PERIOD);
        $display("timeout: the stimulus did not finish in the expected time");
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- test/exec_stimulus.txt
# in:  alu_op neg_src2 br_cond jump load store write_res incr_pc cycle flush pc reg src1 src2 src3
# out: load store write_res pc reg res rd_addr wr_addr wr_word set_pc branch_pc flush_if flush_dc_ex
test reset_idle
0 0 0 0 0 0 0 0 0 0 000 0 0000 0000 0000  0 0 0 000 0 0000 000 000 0000 0 000 0 0
test alu_ops
1 0 0 0 0 0 1 0 0 0 010 1 0005 0003 0000  0 0 1 010 1 0008 000 000 0000 0 000 0 0
1 1 0 0 0 0 1 0 0 0 012 2 0005 0007 0000  0 0 1 012 2 fffe 000 000 0000 0 000 0 0
2 0 0 0 0 0 1 0 0 0 014 3 1234 0100 0000  0 0 1 014 3 3400 000 000 0000 0 000 0 0
2 0 0 0 0 0 1 0 0 0 016 4 ff00 0003 0000  0 0 1 016 4 fd00 000 000 0000 0 000 0 0
3 0 0 0 0 0 1 0 0 0 018 5 0001 0004 0000  0 0 1 018 5 0010 000 000 0000 0 000 0 0
3 0 0 0 0 0 1 0 0 0 01a 6 ffff 0010 0000  0 0 1 01a 6 0000 000 000 0000 0 000 0 0
4 0 0 0 0 0 1 0 0 0 01c 7 8000 0003 0000  0 0 1 01c 7 1000 000 000 0000 0 000 0 0
5 0 0 0 0 0 1 0 0 0 01e 8 8000 0003 0000  0 0 1 01e 8 f000 000 000 0000 0 000 0 0
5 0 0 0 0 0 1 0 0 0 020 9 8421 0014 0000  0 0 1 020 9 ffff 000 000 0000 0 000 0 0
6 0 0 0 0 0 1 0 0 0 022 a f0f0 3c3c 0000  0 0 1 022 a 3030 000 000 0000 0 000 0 0
7 0 0 0 0 0 1 0 0 0 024 b f0f0 0f01 0000  0 0 1 024 b fff1 000 000 0000 0 000 0 0
8 0 0 0 0 0 1 0 0 0 026 c aaaa ffff 0000  0 0 1 026 c 5555 000 000 0000 0 000 0 0
9 0 0 0 0 0 1 0 0 0 028 d 1234 1357 0000  0 0 1 028 d 1357 000 000 0000 0 000 0 0
9 1 0 0 0 0 1 0 0 0 02a e 0000 0001 0000  0 0 1 02a e ffff 000 000 0000 0 000 0 0
0 0 0 0 0 0 1 0 0 0 02c f 1234 5678 0000  0 0 1 02c f 0000 000 000 0000 0 000 0 0
test jump
1 0 0 1 0 0 0 0 0 0 030 0 0100 0234 0000  0 0 0 030 0 0334 000 000 0000 1 334 1 1
1 0 0 1 0 0 0 0 0 0 032 0 a000 0abc 0000  0 0 0 032 0 aabc 000 000 0000 1 abc 1 1
test branch_taken
1 1 1 0 0 0 0 0 0 0 040 0 0042 0042 0000  0 0 0 040 0 0000 000 000 0000 0 000 1 0
1 0 1 0 0 0 0 0 1 0 040 0 0040 0020 0000  0 0 0 040 0 0060 000 000 0000 1 060 1 1
1 1 2 0 0 0 0 0 0 0 050 0 0009 0004 0000  0 0 0 050 0 0005 000 000 0000 0 000 1 0
1 0 2 0 0 0 0 0 1 0 050 0 0050 0020 0000  0 0 0 050 0 0070 000 000 0000 1 070 1 1
1 1 3 0 0 0 0 0 0 0 060 0 0003 0008 0000  0 0 0 060 0 fffb 000 000 0000 0 000 1 0
1 0 3 0 0 0 0 0 1 0 060 0 0060 00a0 0000  0 0 0 060 0 0100 000 000 0000 1 100 1 1
test branch_not_taken
1 1 1 0 0 0 0 0 0 0 070 0 0005 0004 0000  0 0 0 070 0 0001 000 000 0000 0 000 0 0
1 0 1 0 0 0 0 0 1 0 070 0 0070 0010 0000  0 0 0 070 0 0080 000 000 0000 0 000 0 0
1 1 2 0 0 0 0 0 0 0 074 0 0007 0007 0000  0 0 0 074 0 0000 000 000 0000 0 000 0 0
1 0 2 0 0 0 0 0 1 0 074 0 0074 0004 0000  0 0 0 074 0 0078 000 000 0000 0 000 0 0
1 0 3 0 0 0 0 0 0 0 078 0 0002 0003 0000  0 0 0 078 0 0005 000 000 0000 0 000 0 0
1 1 3 0 0 0 0 0 1 0 078 0 0001 0002 0000  0 0 0 078 0 ffff 000 000 0000 0 000 0 0
test memory_and_return
1 0 0 0 1 0 1 0 0 0 080 5 1000 0234 5555  1 0 1 080 5 1234 234 000 0000 0 000 0 0
1 0 0 0 0 1 0 0 0 0 082 0 0f00 00ab beef  0 1 0 082 0 0fab 000 fab beef 0 000 0 0
9 0 0 0 0 0 1 1 0 0 0a4 f 0000 0777 0000  0 0 1 0a4 f 00a6 000 000 0000 0 000 0 0
1 0 0 1 0 0 1 1 0 0 0a6 e 0200 0044 0000  0 0 1 0a6 e 00a8 000 000 0000 1 244 1 1
test flush
1 0 0 0 0 1 1 0 0 1 0b0 3 0100 0011 cafe  0 0 0 000 0 0000 000 000 0000 0 000 0 0
9 0 0 1 0 0 1 1 0 1 0b2 4 0000 0123 0000  0 0 0 000 0 0000 000 000 0000 0 000 0 0
1 1 1 0 0 0 0 0 1 1 0b4 0 0005 0005 0000  0 0 0 000 0 0000 000 000 0000 0 000 0 0
1 0 0 0 0 1 1 0 0 0 0b6 3 0200 0022 1111  0 1 1 0b6 3 0222 000 222 1111 0 000 0 0

//--- src.f
src/exec_pkg.sv
src/exec_input_reg.sv
src/int_alu.sv
src/branch_unit.sv
src/exec_outputs.sv
src/exec_stage.sv
test/exec_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module exec_stage_tb \
    -Mdir obj_dir -o sim_exec_stage || { echo "build failed"; exit 1; }

sim_output=$(./obj_dir/sim_exec_stage)
printf '%s\n' "$sim_output"

printf '%s\n' "$sim_output" | grep -qx "All tests passed" && exit 0 || exit 1
